// File: tile_defines.svh
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Bus widths
`define TILE_ADDR_W 32
`define TILE_DATA_W 32
`define TILE_STRB_W 4

// Local data memory of 1 KiB mirrored over the lower half of the map
`define TILE_DM_WORDS 256
`define TILE_DM_IDX_W 8
`define TILE_DM_SEL_MSB 31

// Boot ROM window 0xF0000000
`define TILE_BOOT_MATCH 4'hF
`define TILE_BOOT_WORDS 16
`define TILE_BOOT_IDX_W 4

// External memory window 0xE0000000
`define TILE_EXT_MATCH 4'hE

// Cycles an external slave gets before the access is aborted
`define TILE_EXT_TIMEOUT 16

`endif

// File: tile_pkg.sv
`include "tile_defines.svh"

package tile_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axil_resp_e;

   typedef enum logic [1:0] {
      SLV_DM,
      SLV_BOOT,
      SLV_EXT,
      SLV_NONE
   } slave_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ACCESS,
      ST_WAIT,
      ST_RESP
   } bus_state_e;

   // Master side of an AXI4-Lite link
   typedef struct packed {
      logic                    awvalid;
      logic [`TILE_ADDR_W-1:0] awaddr;
      logic                    wvalid;
      logic [`TILE_DATA_W-1:0] wdata;
      logic [`TILE_STRB_W-1:0] wstrb;
      logic                    bready;
      logic                    arvalid;
      logic [`TILE_ADDR_W-1:0] araddr;
      logic                    rready;
   } axil_mst_t;

   // What the port drives back
   typedef struct packed {
      logic                    awready;
      logic                    wready;
      logic                    bvalid;
      axil_resp_e              bresp;
      logic                    arready;
      logic                    rvalid;
      logic [`TILE_DATA_W-1:0] rdata;
      axil_resp_e              rresp;
   } axil_slv_t;

   typedef struct packed {
      logic                    valid;
      logic                    write;
      logic [`TILE_ADDR_W-1:0] addr;
      logic [`TILE_DATA_W-1:0] wdata;
      logic [`TILE_STRB_W-1:0] strb;
   } bus_req_t;

   typedef struct packed {
      logic                    valid;
      axil_resp_e              resp;
      logic [`TILE_DATA_W-1:0] rdata;
   } bus_rsp_t;

   // Shared by data memory and boot ROM
   typedef struct packed {
      logic                      en;
      logic                      we;
      logic [`TILE_DM_IDX_W-1:0] idx;
      logic [`TILE_DATA_W-1:0]   wdata;
      logic [`TILE_STRB_W-1:0]   strb;
   } mem_req_t;

   typedef struct packed {
      logic                    valid;
      logic                    we;
      logic [`TILE_ADDR_W-1:0] addr;
      logic [`TILE_DATA_W-1:0] wdata;
      logic [`TILE_STRB_W-1:0] strb;
   } ext_req_t;

endpackage

// File: axil_port.sv
`timescale 1ns/100ps
`include "tile_defines.svh"

module axil_port (
   input  logic                clk,
   input  logic                rst_i,
   input  tile_pkg::axil_mst_t axil_i,
   output tile_pkg::axil_slv_t axil_o,
   output tile_pkg::bus_req_t  bus_req_o,
   input  tile_pkg::bus_rsp_t  bus_rsp_i
);

   logic                    aw_have_q, w_have_q, ar_have_q;
   logic                    aw_have_d, w_have_d, ar_have_d;
   logic                    awready_q, wready_q, arready_q;
   logic                    bvalid_q, rvalid_q;
   logic                    bvalid_d, rvalid_d;
   logic                    aw_hs, w_hs, ar_hs;
   logic                    wr_sel, rsp_wr, rsp_rd, hold_d;
   logic [`TILE_ADDR_W-1:0] awaddr_q, araddr_q;
   logic [`TILE_DATA_W-1:0] wdata_q, rdata_q;
   logic [`TILE_STRB_W-1:0] wstrb_q;
   tile_pkg::axil_resp_e    bresp_q, rresp_q;

   assign aw_hs = axil_i.awvalid & awready_q;
   assign w_hs  = axil_i.wvalid & wready_q;
   assign ar_hs = axil_i.arvalid & arready_q;

   assign wr_sel = aw_have_q & w_have_q;         // Write wins over a held read
   assign rsp_wr = bus_rsp_i.valid & wr_sel;
   assign rsp_rd = bus_rsp_i.valid & ~wr_sel;

   assign aw_have_d = (aw_have_q | aw_hs) & ~rsp_wr;
   assign w_have_d  = (w_have_q | w_hs) & ~rsp_wr;
   assign ar_have_d = (ar_have_q | ar_hs) & ~rsp_rd;
   assign bvalid_d  = (bvalid_q & ~axil_i.bready) | rsp_wr;
   assign rvalid_d  = (rvalid_q & ~axil_i.rready) | rsp_rd;

   // No new channel is taken once a request is complete or a response waits
   assign hold_d = (aw_have_d & w_have_d) | ar_have_d | bvalid_d | rvalid_d;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         aw_have_q <= 1'b0;
         w_have_q  <= 1'b0;
         ar_have_q <= 1'b0;
         bvalid_q  <= 1'b0;
         rvalid_q  <= 1'b0;
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         arready_q <= 1'b0;
      end else begin
         aw_have_q <= aw_have_d;
         w_have_q  <= w_have_d;
         ar_have_q <= ar_have_d;
         bvalid_q  <= bvalid_d;
         rvalid_q  <= rvalid_d;
         awready_q <= ~aw_have_d & ~hold_d;
         wready_q  <= ~w_have_d & ~hold_d;
         arready_q <= ~ar_have_d & ~hold_d;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_hs) begin
         awaddr_q <= axil_i.awaddr;
      end
      if (w_hs) begin
         wdata_q <= axil_i.wdata;
         wstrb_q <= axil_i.wstrb;
      end
      if (ar_hs) begin
         araddr_q <= axil_i.araddr;
      end
      if (rsp_wr) begin
         bresp_q <= bus_rsp_i.resp;
      end
      if (rsp_rd) begin
         rresp_q <= bus_rsp_i.resp;
         rdata_q <= bus_rsp_i.rdata;
      end
   end

   // Request stays up until the bus answers
   assign bus_req_o.valid = (wr_sel | ar_have_q) & ~bvalid_q & ~rvalid_q;
   assign bus_req_o.write = wr_sel;
   assign bus_req_o.addr  = wr_sel ? awaddr_q : araddr_q;
   assign bus_req_o.wdata = wdata_q;
   assign bus_req_o.strb  = wstrb_q;

   assign axil_o.awready = awready_q;
   assign axil_o.wready  = wready_q;
   assign axil_o.bvalid  = bvalid_q;
   assign axil_o.bresp   = bresp_q;
   assign axil_o.arready = arready_q;
   assign axil_o.rvalid  = rvalid_q;
   assign axil_o.rdata   = rdata_q;
   assign axil_o.rresp   = rresp_q;

endmodule

// File: bus_ctrl_fsm.sv
`timescale 1ns/100ps
`include "tile_defines.svh"

module bus_ctrl_fsm (
   input  logic                    clk,
   input  logic                    rst_i,
   input  tile_pkg::bus_req_t      core_req_i,
   input  tile_pkg::bus_req_t      dbg_req_i,
   output tile_pkg::bus_rsp_t      core_rsp_o,
   output tile_pkg::bus_rsp_t      dbg_rsp_o,
   output tile_pkg::mem_req_t      dm_req_o,
   output tile_pkg::mem_req_t      rom_req_o,
   input  logic [`TILE_DATA_W-1:0] dm_rdata_i,
   input  logic [`TILE_DATA_W-1:0] rom_rdata_i,
   output tile_pkg::ext_req_t      ext_req_o,
   input  logic                    ext_ack_i,
   input  logic [`TILE_DATA_W-1:0] ext_rdata_i,
   output logic                    timer_start_o,
   input  logic                    timer_expired_i
);

   tile_pkg::bus_state_e    state_q;
   tile_pkg::bus_req_t      cur_q, sel_req;
   tile_pkg::slave_e        slave_q, sel_slave;
   tile_pkg::axil_resp_e    rsp_resp;
   logic [`TILE_DATA_W-1:0] rsp_rdata;
   logic [`TILE_DATA_W-1:0] ext_rdata_q;
   logic                    rr_q, gnt_q, gnt_dbg;
   logic                    any_req, grant, in_access, in_wait;
   logic                    ext_vld_q, timeout_q, ext_done;

   function automatic tile_pkg::slave_e decode(input logic [`TILE_ADDR_W-1:0] addr);
      if (!addr[`TILE_DM_SEL_MSB]) begin
         return tile_pkg::SLV_DM;
      end else if (addr[`TILE_ADDR_W-1 -: 4] == `TILE_BOOT_MATCH) begin
         return tile_pkg::SLV_BOOT;
      end else if (addr[`TILE_ADDR_W-1 -: 4] == `TILE_EXT_MATCH) begin
         return tile_pkg::SLV_EXT;
      end
      return tile_pkg::SLV_NONE;
   endfunction

   assign any_req   = core_req_i.valid | dbg_req_i.valid;
   assign gnt_dbg   = dbg_req_i.valid & (~core_req_i.valid | rr_q); // rr_q favours debug
   assign sel_req   = gnt_dbg ? dbg_req_i : core_req_i;
   assign sel_slave = decode(sel_req.addr);
   assign grant     = (state_q == tile_pkg::ST_IDLE) & any_req;
   assign in_access = (state_q == tile_pkg::ST_ACCESS);
   assign in_wait   = (state_q == tile_pkg::ST_WAIT);
   assign ext_done  = ext_ack_i | timer_expired_i;

   assign timer_start_o = grant & (sel_slave == tile_pkg::SLV_EXT); // Window opens at grant

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q   <= tile_pkg::ST_IDLE;
         rr_q      <= 1'b0;
         ext_vld_q <= 1'b0;
      end else begin
         case (state_q)
            tile_pkg::ST_IDLE: begin
               if (any_req) begin
                  state_q   <= tile_pkg::ST_ACCESS;
                  ext_vld_q <= (sel_slave == tile_pkg::SLV_EXT);
               end
            end
            tile_pkg::ST_ACCESS: begin
               if (slave_q != tile_pkg::SLV_EXT || ext_done) begin // Memories take one cycle
                  state_q   <= tile_pkg::ST_WAIT;
                  ext_vld_q <= 1'b0;
               end
            end
            tile_pkg::ST_WAIT: begin
               state_q <= tile_pkg::ST_RESP;
            end
            default: begin
               state_q <= tile_pkg::ST_IDLE;
               rr_q    <= ~gnt_q;                              // Other port next
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (grant) begin
         cur_q   <= sel_req;
         gnt_q   <= gnt_dbg;
         slave_q <= sel_slave;
      end
      if (in_access && slave_q == tile_pkg::SLV_EXT) begin
         timeout_q   <= ~ext_ack_i & timer_expired_i;           // Ack beats a late expiry
         ext_rdata_q <= ext_ack_i ? ext_rdata_i : '0;
      end
   end

   // Slave strobes
   always_comb begin
      dm_req_o.en     = in_access & (slave_q == tile_pkg::SLV_DM);
      dm_req_o.we     = cur_q.write;
      dm_req_o.idx    = cur_q.addr[`TILE_DM_IDX_W+1:2];
      dm_req_o.wdata  = cur_q.wdata;
      dm_req_o.strb   = cur_q.strb;
      rom_req_o.en    = in_access & (slave_q == tile_pkg::SLV_BOOT);
      rom_req_o.we    = cur_q.write;
      rom_req_o.idx   = {{(`TILE_DM_IDX_W-`TILE_BOOT_IDX_W){1'b0}},
                         cur_q.addr[`TILE_BOOT_IDX_W+1:2]};
      rom_req_o.wdata = cur_q.wdata;
      rom_req_o.strb  = cur_q.strb;
   end

   assign ext_req_o.valid = ext_vld_q;
   assign ext_req_o.we    = cur_q.write;
   assign ext_req_o.addr  = cur_q.addr;
   assign ext_req_o.wdata = cur_q.wdata;
   assign ext_req_o.strb  = cur_q.strb;

   // Response is formed as the slave data lands
   always_comb begin
      rsp_resp  = tile_pkg::OKAY;
      rsp_rdata = '0;
      case (slave_q)
         tile_pkg::SLV_DM: begin
            rsp_rdata = dm_rdata_i;
         end
         tile_pkg::SLV_BOOT: begin
            rsp_rdata = rom_rdata_i;
            if (cur_q.write) begin
               rsp_resp = tile_pkg::SLVERR;                    // ROM is read-only
            end
         end
         tile_pkg::SLV_EXT: begin
            rsp_rdata = ext_rdata_q;
            if (timeout_q) begin
               rsp_resp = tile_pkg::SLVERR;
            end
         end
         default: begin
            rsp_resp = tile_pkg::DECERR;
         end
      endcase
   end

   assign core_rsp_o.valid = in_wait & ~gnt_q;
   assign core_rsp_o.resp  = rsp_resp;
   assign core_rsp_o.rdata = rsp_rdata;
   assign dbg_rsp_o.valid  = in_wait & gnt_q;
   assign dbg_rsp_o.resp   = rsp_resp;
   assign dbg_rsp_o.rdata  = rsp_rdata;

endmodule

// File: access_timer.sv
`timescale 1ns/100ps
`include "tile_defines.svh"

module access_timer (
   input  logic clk,
   input  logic rst_i,
   input  logic start_i,
   output logic expired_o
);

   localparam int CNT_W = $clog2(`TILE_EXT_TIMEOUT);
   localparam logic [CNT_W-1:0] LOAD = CNT_W'(`TILE_EXT_TIMEOUT - 1); // Start cycle counts too

   logic [CNT_W-1:0] cnt_q;
   logic             busy_q;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
      end else if (start_i) begin
         busy_q <= 1'b1;                                       // Restart drops any old count
         cnt_q  <= LOAD;
      end else if (busy_q) begin
         if (cnt_q == '0) begin
            busy_q <= 1'b0;
         end else begin
            cnt_q <= cnt_q - 1'b1;
         end
      end
   end

   assign expired_o = busy_q & (cnt_q == '0);                  // Single-cycle pulse

endmodule

// File: dm_sram.sv
`timescale 1ns/100ps
`include "tile_defines.svh"

module dm_sram (
   input  logic                    clk,
   input  tile_pkg::mem_req_t      req_i,
   output logic [`TILE_DATA_W-1:0] rdata_o
);

   logic [`TILE_DATA_W-1:0] mem_q [0:`TILE_DM_WORDS-1];

   always_ff @(posedge clk) begin
      if (req_i.en) begin
         if (req_i.we) begin
            for (int b = 0; b < `TILE_STRB_W; b++) begin
               if (req_i.strb[b]) begin
                  mem_q[req_i.idx][8*b +: 8] <= req_i.wdata[8*b +: 8]; // Byte lane merge
               end
            end
         end
         rdata_o <= mem_q[req_i.idx];                          // Old word on a write
      end
   end

endmodule

// File: boot_rom.sv
`timescale 1ns/100ps
`include "tile_defines.svh"

module boot_rom (
   input  logic                    clk,
   input  tile_pkg::mem_req_t      req_i,
   output logic [`TILE_DATA_W-1:0] rdata_o
);

   logic [`TILE_DATA_W-1:0] rom_q [0:`TILE_BOOT_WORDS-1];

   initial begin
      $readmemh("boot_rom.hex", rom_q);
   end

   // Write enable has no effect here
   always_ff @(posedge clk) begin
      if (req_i.en) begin
         rdata_o <= rom_q[req_i.idx[`TILE_BOOT_IDX_W-1:0]];
      end
   end

endmodule

// File: compute_tile_bus.sv
`timescale 1ns/100ps
`include "tile_defines.svh"

module compute_tile_bus (
   input  logic                    clk,
   input  logic                    rst_i,
   input  tile_pkg::axil_mst_t     core_req_i,
   output tile_pkg::axil_slv_t     core_rsp_o,
   input  tile_pkg::axil_mst_t     dbg_req_i,
   output tile_pkg::axil_slv_t     dbg_rsp_o,
   output tile_pkg::ext_req_t      ext_req_o,
   input  logic                    ext_ack_i,
   input  logic [`TILE_DATA_W-1:0] ext_rdata_i
);

   tile_pkg::bus_req_t      core_bus_req, dbg_bus_req;
   tile_pkg::bus_rsp_t      core_bus_rsp, dbg_bus_rsp;
   tile_pkg::mem_req_t      dm_req, rom_req;
   logic [`TILE_DATA_W-1:0] dm_rdata, rom_rdata;
   logic                    timer_start, timer_expired;

   axil_port u_core_port (                                     // Core data port
      .clk       (clk),
      .rst_i     (rst_i),
      .axil_i    (core_req_i),
      .axil_o    (core_rsp_o),
      .bus_req_o (core_bus_req),
      .bus_rsp_i (core_bus_rsp)
   );

   axil_port u_dbg_port (                                      // Debug memory access
      .clk       (clk),
      .rst_i     (rst_i),
      .axil_i    (dbg_req_i),
      .axil_o    (dbg_rsp_o),
      .bus_req_o (dbg_bus_req),
      .bus_rsp_i (dbg_bus_rsp)
   );

   bus_ctrl_fsm u_bus_ctrl (
      .clk             (clk),
      .rst_i           (rst_i),
      .core_req_i      (core_bus_req),
      .dbg_req_i       (dbg_bus_req),
      .core_rsp_o      (core_bus_rsp),
      .dbg_rsp_o       (dbg_bus_rsp),
      .dm_req_o        (dm_req),
      .rom_req_o       (rom_req),
      .dm_rdata_i      (dm_rdata),
      .rom_rdata_i     (rom_rdata),
      .ext_req_o       (ext_req_o),
      .ext_ack_i       (ext_ack_i),
      .ext_rdata_i     (ext_rdata_i),
      .timer_start_o   (timer_start),
      .timer_expired_i (timer_expired)
   );

   access_timer u_timer (                                      // External watchdog
      .clk       (clk),
      .rst_i     (rst_i),
      .start_i   (timer_start),
      .expired_o (timer_expired)
   );

   dm_sram u_dm (
      .clk     (clk),
      .req_i   (dm_req),
      .rdata_o (dm_rdata)
   );

   boot_rom u_rom (
      .clk     (clk),
      .req_i   (rom_req),
      .rdata_o (rom_rdata)
   );

endmodule

// File: tb_compute_tile.sv
`timescale 1ns/100ps
`include "tile_defines.svh"

module tb_compute_tile;

   localparam logic [7:0] NEVER = 8'hFF;                       // Responder stays silent
   localparam int N_CONC = 12;                                 // Random transactions per port

   typedef struct packed {
      logic                    port;                           // 0 core, 1 debug
      logic                    wr;
      logic [`TILE_ADDR_W-1:0] addr;
      logic [`TILE_DATA_W-1:0] wdata;
      logic [`TILE_STRB_W-1:0] strb;
      logic [7:0]              ack_dly;
      tile_pkg::axil_resp_e    resp;
      logic [`TILE_DATA_W-1:0] rdata;
   } entry_t;

   logic                    clk = 1'b0;
   logic                    rst_i;
   tile_pkg::axil_mst_t     mst [2];
   tile_pkg::axil_slv_t     slv [2];
   tile_pkg::ext_req_t      ext_req, exp_ext;
   logic                    ext_ack;
   logic [`TILE_DATA_W-1:0] ext_rdata;
   logic [`TILE_DATA_W-1:0] dm_model [0:`TILE_DM_WORDS-1];
   logic                    dm_known [0:`TILE_DM_WORDS-1];
   logic [`TILE_DATA_W-1:0] rom_img [0:`TILE_BOOT_WORDS-1];
   entry_t                  tbl [$];
   int                      cyc = 0;
   int                      ext_count = 0;
   int                      ext_delay = 0;
   int                      ext_rise_cyc = 0;

   compute_tile_bus dut_i (
      .clk         (clk),
      .rst_i       (rst_i),
      .core_req_i  (mst[0]),
      .core_rsp_o  (slv[0]),
      .dbg_req_i   (mst[1]),
      .dbg_rsp_o   (slv[1]),
      .ext_req_o   (ext_req),
      .ext_ack_i   (ext_ack),
      .ext_rdata_i (ext_rdata)
   );

   always #2 clk = ~clk;
   always @(posedge clk) cyc <= cyc + 1;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic expect_resp(input string name, input tile_pkg::axil_resp_e got,
                              input tile_pkg::axil_resp_e exp);
      if (got !== exp) begin
         abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
      end
   endtask

   task automatic check_word(input string name, input logic [`TILE_DATA_W-1:0] got,
                             input logic [`TILE_DATA_W-1:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
      end
   endtask

   // Write data and strobe only mean something on a write
   task automatic verify_ext(input string name, input tile_pkg::ext_req_t got,
                             input tile_pkg::ext_req_t exp);
      if (got.valid !== exp.valid || got.we !== exp.we || got.addr !== exp.addr ||
          (exp.we && (got.wdata !== exp.wdata || got.strb !== exp.strb))) begin
         abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
      end
   endtask

   function automatic logic [`TILE_DATA_W-1:0] model_rdata(input logic [31:0] addr);
      if (!addr[31]) begin
         return dm_model[addr[9:2]];                           // Upper bits alias
      end
      if (addr[31:28] == `TILE_BOOT_MATCH) begin
         return rom_img[addr[5:2]];
      end
      if (addr[31:28] == `TILE_EXT_MATCH) begin
         return addr ^ 32'hA5A5A5A5;
      end
      return '0;
   endfunction

   function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                       input logic [3:0] strb);
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            dm_model[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
         end
      end
      if (strb == 4'hF) begin
         dm_known[addr[9:2]] = 1'b1;
      end
   endfunction

   function automatic void add_row(input logic port, input logic wr, input logic [31:0] addr,
                                   input logic [3:0] strb, input logic [7:0] dly,
                                   input tile_pkg::axil_resp_e resp);
      tbl.push_back({port, wr, addr, 32'($urandom), strb, dly, resp, 32'h0});
   endfunction

   task automatic build_table();
      add_row(1'b0, 1'b1, 32'h0000_0000, 4'hF, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b1, 32'h0000_0010, 4'hF, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b1, 32'h0000_0010, 4'h5, 8'd0, tile_pkg::OKAY);
      add_row(1'b1, 1'b1, 32'h0000_0014, 4'hF, 8'd0, tile_pkg::OKAY);
      add_row(1'b1, 1'b1, 32'h0000_0014, 4'hA, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b0, 32'h0000_0010, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b1, 1'b0, 32'h0000_0414, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b1, 32'h0000_0C10, 4'h2, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b0, 32'h0000_0010, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b1, 1'b0, 32'h4000_0014, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b0, 32'hF000_0000, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b1, 1'b0, 32'hF000_003C, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b1, 32'hF000_0008, 4'hF, 8'd0, tile_pkg::SLVERR);
      add_row(1'b0, 1'b0, 32'hF000_0008, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b1, 32'h9000_0000, 4'hF, 8'd0, tile_pkg::DECERR);
      add_row(1'b1, 1'b0, 32'h9000_0010, 4'h0, 8'd0, tile_pkg::DECERR);
      add_row(1'b0, 1'b0, 32'h0000_0000, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b1, 32'hE000_0100, 4'hF, 8'd2, tile_pkg::OKAY);
      add_row(1'b1, 1'b0, 32'hE000_0204, 4'h0, 8'd0, tile_pkg::OKAY);
      add_row(1'b0, 1'b0, 32'hE000_1000, 4'h0, 8'd10, tile_pkg::OKAY);
      add_row(1'b1, 1'b1, 32'hE000_0300, 4'h3, NEVER, tile_pkg::SLVERR);
      add_row(1'b0, 1'b0, 32'hE000_0400, 4'h0, NEVER, tile_pkg::SLVERR);
      add_row(1'b1, 1'b0, 32'hA000_0000, 4'h0, 8'd0, tile_pkg::DECERR);
   endtask

   // One AXI4-Lite transaction entered and left 1 ns after a rising edge
   task automatic transact(input logic p, input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb, input int bp,
                           output tile_pkg::axil_resp_e resp, output logic [31:0] rdata,
                           output int lat, output int rc);
      logic aw_left, w_left, ar_left, aw_take, w_take, ar_take, vld;
      aw_left = wr;
      w_left  = wr;
      ar_left = ~wr;
      mst[p].awvalid = wr;
      mst[p].awaddr  = addr;
      mst[p].wvalid  = wr;
      mst[p].wdata   = wdata;
      mst[p].wstrb   = strb;
      mst[p].arvalid = ~wr;
      mst[p].araddr  = addr;
      while (aw_left || w_left || ar_left) begin
         @(negedge clk);
         aw_take = mst[p].awvalid & slv[p].awready;
         w_take  = mst[p].wvalid & slv[p].wready;
         ar_take = mst[p].arvalid & slv[p].arready;
         @(posedge clk);
         #1;
         if (aw_take) begin
            mst[p].awvalid = 1'b0;
            aw_left = 1'b0;
         end
         if (w_take) begin
            mst[p].wvalid = 1'b0;
            w_left = 1'b0;
         end
         if (ar_take) begin
            mst[p].arvalid = 1'b0;
            ar_left = 1'b0;
         end
      end
      lat = 0;
      vld = 1'b0;
      while (!vld) begin
         @(negedge clk);
         vld = wr ? slv[p].bvalid : slv[p].rvalid;
         if (!vld) begin
            lat++;
         end
      end
      rc    = cyc;
      resp  = wr ? slv[p].bresp : slv[p].rresp;
      rdata = slv[p].rdata;
      repeat (bp) begin                                        // Response must not move
         @(posedge clk);
         #1;
         @(negedge clk);
         check_word("valid held", {31'b0, wr ? slv[p].bvalid : slv[p].rvalid}, 32'h1);
         expect_resp("resp held", wr ? slv[p].bresp : slv[p].rresp, resp);
         if (!wr) begin
            check_word("rdata held", slv[p].rdata, rdata);
         end
      end
      @(posedge clk);
      #1;
      mst[p].bready = wr;
      mst[p].rready = ~wr;
      @(posedge clk);
      #1;
      mst[p].bready = 1'b0;
      mst[p].rready = 1'b0;
   endtask

   task automatic random_traffic(input logic p);
      logic [31:0]          rnd, addr, wdata, got_d;
      logic [7:0]           idx;
      logic [3:0]           strb;
      logic                 wr;
      tile_pkg::axil_resp_e got_r;
      int                   bp, lat, rc;
      repeat (N_CONC) begin
         rnd   = $urandom;
         idx   = {3'b001, p, rnd[3:0]};                        // Each port owns 16 words
         addr  = {1'b0, rnd[30:10], idx, 2'b00};
         wr    = rnd[4] | ~dm_known[idx];
         strb  = dm_known[idx] ? rnd[8:5] : 4'hF;
         wdata = $urandom;
         bp    = $urandom % 6;
         transact(p, wr, addr, wdata, strb, bp, got_r, got_d, lat, rc);
         expect_resp("random resp", got_r, tile_pkg::OKAY);
         if (wr) begin
            model_write(addr, wdata, strb);
         end else begin
            check_word("random rdata", got_d, dm_model[idx]);
         end
      end
   endtask

   // External slave that answers with the address XOR 0xA5A5A5A5
   initial begin : ext_responder
      int left;
      ext_ack   = 1'b0;
      ext_rdata = '0;
      forever begin
         @(negedge clk);
         if (ext_req.valid) begin
            ext_count++;
            ext_rise_cyc = cyc;
            left = ext_delay;
            while (ext_req.valid) begin
               verify_ext("ext_req_o", ext_req, exp_ext);
               if (left == 0) begin
                  @(posedge clk);
                  #1;
                  ext_ack   = 1'b1;
                  ext_rdata = ext_req.addr ^ 32'hA5A5A5A5;
                  @(posedge clk);
                  #1;
                  ext_ack = 1'b0;
               end
               left--;
               @(negedge clk);
            end
         end
      end
   end

   initial begin : watchdog
      int limit;
      @(negedge rst_i);
      limit = (tbl.size() + 2 * N_CONC + 64) * (`TILE_EXT_TIMEOUT + 20);
      repeat (limit) @(posedge clk);
      abort_run("Watchdog expired because a transaction never completed");
   end

   initial begin : main_seq
      entry_t               e;
      tile_pkg::axil_resp_e got_r;
      logic [31:0]          got_d;
      int                   lat, rc, n_ext;
      logic                 is_ext;
      string                tag;
      void'($urandom(19));
      $readmemh("boot_rom.hex", rom_img);
      for (int i = 0; i < `TILE_DM_WORDS; i++) begin
         dm_model[i] = '0;
         dm_known[i] = 1'b0;
      end
      mst[0] = '0;
      mst[1] = '0;
      rst_i  = 1'b1;
      build_table();
      repeat (4) @(posedge clk);
      @(negedge clk);
      check_word("core control in reset", {27'b0, slv[0].awready, slv[0].wready,
                 slv[0].arready, slv[0].bvalid, slv[0].rvalid}, '0);
      check_word("debug control in reset", {27'b0, slv[1].awready, slv[1].wready,
                 slv[1].arready, slv[1].bvalid, slv[1].rvalid}, '0);
      check_word("ext_req_o.valid in reset", {31'b0, ext_req.valid}, '0);
      @(posedge clk);
      #1;
      rst_i = 1'b0;

      foreach (tbl[i]) begin
         e   = tbl[i];
         tag = $sformatf("row %0d", i);
         if (!e.wr) begin
            e.rdata = model_rdata(e.addr);
         end
         exp_ext.valid = 1'b1;
         exp_ext.we    = e.wr;
         exp_ext.addr  = e.addr;
         exp_ext.wdata = e.wdata;
         exp_ext.strb  = e.strb;
         ext_delay = (e.ack_dly == NEVER) ? -1 : {24'b0, e.ack_dly};
         n_ext = ext_count;
         transact(e.port, e.wr, e.addr, e.wdata, e.strb, 0, got_r, got_d, lat, rc);
         expect_resp({tag, " resp"}, got_r, e.resp);
         if (!e.wr && e.resp != tile_pkg::SLVERR) begin
            check_word({tag, " rdata"}, got_d, e.rdata);
         end
         is_ext = (e.addr[31:28] == `TILE_EXT_MATCH);
         check_word({tag, " ext_req count"}, ext_count - n_ext, is_ext ? 1 : 0);
         if (!is_ext) begin
            check_word({tag, " latency"}, lat, 3);
         end else if (e.ack_dly == NEVER && rc - ext_rise_cyc < `TILE_EXT_TIMEOUT) begin
            abort_run($sformatf("%s timed out after only %0d cycles", tag,
                                rc - ext_rise_cyc));
         end
         if (e.wr && e.resp == tile_pkg::OKAY && !e.addr[31]) begin
            model_write(e.addr, e.wdata, e.strb);
         end
      end

      fork
         random_traffic(1'b0);
         random_traffic(1'b1);
      join

      for (int i = 0; i < 64; i++) begin                       // Final memory contents
         if (dm_known[i]) begin
            transact(1'b1, 1'b0, {22'b0, i[7:0], 2'b00}, '0, '0, 0, got_r, got_d, lat, rc);
            expect_resp("readback resp", got_r, tile_pkg::OKAY);
            check_word($sformatf("readback word %0d", i), got_d, dm_model[i]);
         end
      end

      $display("all tests passed");
      $finish;
   end

endmodule

// File: boot_rom.hex
// One 32-bit boot image word per line, word 0 at 0xF0000000
00000297
02028293
30529073
00001137
80010113
00000517
03c50513
00a00593
00b52023
00450513
fff58593
fe059ae3
0000100f
10500073
ffdff06f
00000013

// File: tb.f
+incdir+.
tile_pkg.sv
axil_port.sv
bus_ctrl_fsm.sv
access_timer.sv
dm_sram.sv
boot_rom.sv
compute_tile_bus.sv
tb_compute_tile.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_compute_tile \
   -f tb.f -o tb_sim > build.log 2>&1 &&
   ./obj_dir/tb_sim > sim.log 2>&1
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
